// File: hw/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// fetch address split
`define ICACHE_ADDR_W     32
`define ICACHE_OFFSET_W   5
`define ICACHE_INDEX_W    6
`define ICACHE_TAG_W      21

// geometry: 64 sets, 2 ways, 32 byte lines
`define ICACHE_SETS       64
// each way is two banks of 16 bytes
`define ICACHE_BANK_W     128

// one line refill is four 64-bit beats
`define ICACHE_LINE_BEATS 4

// axi read channel
`define AXI_DATA_W        64
`define AXI_ID_W          4
`define AXI_ICACHE_ID     0

`endif

// File: hw/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

  // field view of a fetch address
  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } icache_addr_fields_t;

  // raw word for the bus side, fields for lookup
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    icache_addr_fields_t       f;
  } icache_addr_t;

  // cache controller states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    MISS   = 2'd2,
    REFILL = 2'd3
  } icache_state_t;

endpackage

// File: hw/refill_if.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

interface refill_if import icache_pkg::*;;

  // line request, held until accepted
  logic                   rd_req;
  icache_addr_t           rd_addr;
  logic                   rd_ready;

  // returned beats, one cycle each
  logic [`AXI_DATA_W-1:0] rdata;
  logic                   rvalid;
  logic                   rlast;

  modport ctrl (
    output rd_req, rd_addr,
    input  rd_ready, rdata, rvalid, rlast
  );

  modport master (
    input  rd_req, rd_addr,
    output rd_ready, rdata, rvalid, rlast
  );

endinterface

// File: hw/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_tag_array import icache_pkg::*; (
  input  logic         clk,
  input  logic         i_reset,
  input  logic         i_rd_en,
  input  icache_addr_t i_addr,
  input  logic         i_fill_en,
  input  logic         i_fill_way,
  input  logic         i_touch_en,
  output logic         o_hit,
  output logic         o_hit_way,
  output logic         o_victim_way
);

  logic [`ICACHE_TAG_W-1:0]  tag_mem [2][`ICACHE_SETS];
  logic [1:0][`ICACHE_SETS-1:0] valid_q;
  // lru_q holds the least recently used way of each set
  logic [`ICACHE_SETS-1:0]   lru_q;

  logic [`ICACHE_TAG_W-1:0]  rd_tag_q [2];
  logic [`ICACHE_TAG_W-1:0]  req_tag_q;
  logic [1:0]                rd_valid_q;
  logic                      rd_lru_q;
  logic [1:0]                way_match;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      valid_q    <= '0;
      lru_q      <= '0;
      rd_valid_q <= '0;
    end else begin
      if (i_fill_en) begin
        valid_q[i_fill_way][i_addr.f.index] <= 1'b1;
      end
      // filled or touched way becomes most recent
      if (i_fill_en || i_touch_en) begin
        lru_q[i_addr.f.index] <= ~i_fill_way;
      end
      if (i_rd_en) begin
        rd_valid_q <= {valid_q[1][i_addr.f.index], valid_q[0][i_addr.f.index]};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_fill_en) begin
      tag_mem[i_fill_way][i_addr.f.index] <= i_addr.f.tag;
    end
    if (i_rd_en) begin
      rd_tag_q[0] <= tag_mem[0][i_addr.f.index];
      rd_tag_q[1] <= tag_mem[1][i_addr.f.index];
      req_tag_q   <= i_addr.f.tag;
      rd_lru_q    <= lru_q[i_addr.f.index];
    end
  end

  assign way_match[0] = rd_valid_q[0] && (rd_tag_q[0] == req_tag_q);
  assign way_match[1] = rd_valid_q[1] && (rd_tag_q[1] == req_tag_q);

  assign o_hit     = |way_match;
  assign o_hit_way = way_match[1];
  // empty way first, then lru
  assign o_victim_way = !rd_valid_q[0] ? 1'b0 : (!rd_valid_q[1] ? 1'b1 : rd_lru_q);

  // a line is never cached in both ways
  a_single_way_hit: assert property (@(posedge clk) disable iff (i_reset)
    !(way_match[0] && way_match[1]));

endmodule

// File: hw/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

// banks 0/1 are way 0, banks 2/3 are way 1
// even bank holds bytes 0..15 of a line, odd bank bytes 16..31
module icache_data_array (
  input  logic                              clk,
  input  logic [3:0]                        i_cen,
  input  logic [3:0]                        i_wen,
  input  logic [`ICACHE_INDEX_W-1:0]        i_addr,
  input  logic [3:0][`ICACHE_BANK_W-1:0]    i_wmask,
  input  logic [3:0][`ICACHE_BANK_W-1:0]    i_wdata,
  output logic [3:0][`ICACHE_BANK_W-1:0]    o_rdata
);

  for (genvar b = 0; b < 4; b++) begin : g_bank
    logic [`ICACHE_BANK_W-1:0] mem [`ICACHE_SETS];
    logic [`ICACHE_BANK_W-1:0] rdata_q;

    // single port sram with bit write mask
    always_ff @(posedge clk) begin
      if (i_cen[b]) begin
        if (i_wen[b]) begin
          mem[i_addr] <= (mem[i_addr] & ~i_wmask[b]) | (i_wdata[b] & i_wmask[b]);
        end else begin
          rdata_q <= mem[i_addr];
        end
      end
    end

    assign o_rdata[b] = rdata_q;
  end

endmodule

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic                           clk,
  input  logic                           i_reset,
  // fetch port
  input  logic                           i_req,
  input  icache_addr_t                   i_addr,
  output logic                           o_req_ready,
  output logic [`AXI_DATA_W-1:0]         o_rdata,
  output logic                           o_rvalid,
  output logic [31:0]                    o_hit_count,
  output logic [31:0]                    o_req_count,
  // line refill
  refill_if.ctrl                         rd,
  // tag array
  output logic                           o_tag_rd_en,
  output icache_addr_t                   o_tag_addr,
  output logic                           o_tag_fill_en,
  output logic                           o_tag_fill_way,
  output logic                           o_tag_touch_en,
  input  logic                           i_tag_hit,
  input  logic                           i_tag_hit_way,
  input  logic                           i_tag_victim_way,
  // data array
  output logic [3:0]                     o_data_cen,
  output logic [3:0]                     o_data_wen,
  output logic [`ICACHE_INDEX_W-1:0]     o_data_addr,
  output logic [3:0][`ICACHE_BANK_W-1:0] o_data_wmask,
  output logic [3:0][`ICACHE_BANK_W-1:0] o_data_wdata,
  input  logic [3:0][`ICACHE_BANK_W-1:0] i_data_rdata
);

  localparam int DW_LSB   = $clog2(`AXI_DATA_W / 8);
  localparam int BANK_BIT = `ICACHE_OFFSET_W - 1;
  localparam int BEAT_W   = $clog2(`ICACHE_LINE_BEATS);

  icache_state_t             state_q, state_d;
  icache_addr_t              addr_q, lookup_addr;
  logic                      ready_q, rvalid_q, rvalid_d;
  logic [`AXI_DATA_W-1:0]    rdata_q, hit_dword;
  logic                      victim_q;
  logic [BEAT_W-1:0]         beat_q, req_dword;
  logic [31:0]               hit_cnt_q, req_cnt_q;
  logic                      accept, lookup_hit, beat_wr, last_beat;
  logic [1:0]                hit_bank, fill_bank;
  logic [`ICACHE_BANK_W-1:0] hit_line, beat_mask;

  assign accept     = i_req && ready_q;
  assign lookup_hit = (state_q == LOOKUP) && i_tag_hit;
  assign beat_wr    = (state_q == REFILL) && rd.rvalid;
  assign last_beat  = beat_wr && rd.rlast;
  assign rvalid_d   = lookup_hit || last_beat;
  assign req_dword  = addr_q.f.offset[BANK_BIT:DW_LSB];

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (accept) state_d = LOOKUP;
      LOOKUP:  state_d = i_tag_hit ? IDLE : MISS;
      MISS:    if (rd.rd_req && rd.rd_ready) state_d = REFILL;
      REFILL:  if (last_beat) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // arrays see the incoming address only while idle
  assign lookup_addr    = (state_q == IDLE) ? i_addr : addr_q;
  assign o_tag_rd_en    = accept;
  assign o_tag_addr     = lookup_addr;
  assign o_tag_touch_en = lookup_hit;
  assign o_tag_fill_en  = last_beat;
  assign o_tag_fill_way = (state_q == LOOKUP) ? i_tag_hit_way : victim_q;

  // hit path: way and half-line pick the bank, offset bit 3 the doubleword
  assign hit_bank  = {i_tag_hit_way, addr_q.f.offset[BANK_BIT]};
  assign hit_line  = i_data_rdata[hit_bank];
  assign hit_dword = addr_q.f.offset[DW_LSB] ? hit_line[`AXI_DATA_W +: `AXI_DATA_W]
                                             : hit_line[0 +: `AXI_DATA_W];

  // refill path: beats 0,1 to the low bank, 2,3 to the high bank
  assign fill_bank    = {victim_q, beat_q[1]};
  assign beat_mask    = {{`AXI_DATA_W{beat_q[0]}}, {`AXI_DATA_W{~beat_q[0]}}};
  assign o_data_addr  = lookup_addr.f.index;
  assign o_data_wen   = beat_wr ? (4'b0001 << fill_bank) : 4'b0000;
  assign o_data_cen   = accept ? 4'b1111 : o_data_wen;
  assign o_data_wmask = {4{beat_mask}};
  assign o_data_wdata = {8{rd.rdata}};

  assign rd.rd_req          = (state_q == MISS);
  assign rd.rd_addr.f.tag   = addr_q.f.tag;
  assign rd.rd_addr.f.index = addr_q.f.index;
  assign rd.rd_addr.f.offset = '0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q   <= IDLE;
      ready_q   <= 1'b0;
      rvalid_q  <= 1'b0;
      beat_q    <= '0;
      hit_cnt_q <= '0;
      req_cnt_q <= '0;
    end else begin
      state_q  <= state_d;
      // ready returns the cycle after the data pulse
      ready_q  <= (state_q == IDLE) && (state_d == IDLE);
      rvalid_q <= rvalid_d;
      if (state_q == MISS) begin
        beat_q <= '0;
      end else if (beat_wr) begin
        beat_q <= beat_q + 1'b1;
      end
      if (accept) req_cnt_q <= req_cnt_q + 32'd1;
      if (lookup_hit) hit_cnt_q <= hit_cnt_q + 32'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) addr_q <= i_addr;
    if (state_q == LOOKUP) victim_q <= i_tag_victim_way;
    if (lookup_hit) begin
      rdata_q <= hit_dword;
    end else if (beat_wr && (beat_q == req_dword)) begin
      // keep the requested doubleword as it streams past
      rdata_q <= rd.rdata;
    end
  end

  assign o_req_ready = ready_q;
  assign o_rvalid    = rvalid_q;
  assign o_rdata     = rdata_q;
  assign o_hit_count = hit_cnt_q;
  assign o_req_count = req_cnt_q;

  a_busy_while_valid: assert property (@(posedge clk) disable iff (i_reset)
    !(o_rvalid && o_req_ready));

  a_refill_req_held: assert property (@(posedge clk) disable iff (i_reset)
    (rd.rd_req && !rd.rd_ready) |=> (rd.rd_req && $stable(rd.rd_addr)));

endmodule

// File: hw/axi_read_master.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module axi_read_master import icache_pkg::*; (
  input  logic                    clk,
  input  logic                    i_reset,
  refill_if.master                rd,
  // ar channel
  output logic                    o_arvalid,
  input  logic                    i_arready,
  output logic [`ICACHE_ADDR_W-1:0] o_araddr,
  output logic [`AXI_ID_W-1:0]    o_arid,
  output logic [7:0]              o_arlen,
  output logic [2:0]              o_arsize,
  output logic [1:0]              o_arburst,
  // r channel
  output logic                    o_rready,
  input  logic                    i_rvalid,
  input  logic [`AXI_DATA_W-1:0]  i_rdata,
  input  logic                    i_rlast,
  input  logic [1:0]              i_rresp,
  input  logic [`AXI_ID_W-1:0]    i_rid
);

  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam int         BEAT_W     = $clog2(`ICACHE_LINE_BEATS);

  icache_addr_t      araddr_q;
  logic              arvalid_q, rready_q;
  logic [BEAT_W-1:0] beat_q;
  logic              accept, r_beat;

  // one burst at a time
  assign rd.rd_ready = !arvalid_q && !rready_q;
  assign accept      = rd.rd_req && rd.rd_ready;
  assign r_beat      = i_rvalid && rready_q;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
      beat_q    <= '0;
    end else begin
      if (accept) begin
        arvalid_q <= 1'b1;
      end else if (arvalid_q && i_arready) begin
        arvalid_q <= 1'b0;
        rready_q  <= 1'b1;
      end
      if (r_beat) begin
        beat_q <= beat_q + 1'b1;
        if (i_rlast) rready_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) araddr_q <= rd.rd_addr;
  end

  // fixed line burst: 4 beats of 8 bytes, incrementing
  assign o_arvalid = arvalid_q;
  assign o_araddr  = araddr_q.raw;
  assign o_arid    = `AXI_ID_W'(`AXI_ICACHE_ID);
  assign o_arlen   = 8'(`ICACHE_LINE_BEATS - 1);
  assign o_arsize  = 3'($clog2(`AXI_DATA_W / 8));
  assign o_arburst = BURST_INCR;
  assign o_rready  = rready_q;

  // beats go straight through, error responses are not acted on
  assign rd.rdata  = i_rdata;
  assign rd.rvalid = r_beat;
  assign rd.rlast  = r_beat && i_rlast;

  a_araddr_stable: assert property (@(posedge clk) disable iff (i_reset)
    (o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr)));

  a_rlast_on_fourth: assert property (@(posedge clk) disable iff (i_reset)
    r_beat |-> (i_rlast == (beat_q == BEAT_W'(`ICACHE_LINE_BEATS - 1))));

  a_rid_match: assert property (@(posedge clk) disable iff (i_reset)
    r_beat |-> (i_rid == o_arid));

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ps
`include "icache_settings.svh"

module icache_top import icache_pkg::*; (
  input  logic                      clk,
  input  logic                      i_reset,
  // fetch port
  input  logic                      i_req,
  input  logic [`ICACHE_ADDR_W-1:0] i_addr,
  output logic                      o_req_ready,
  output logic [`AXI_DATA_W-1:0]    o_rdata,
  output logic                      o_rvalid,
  output logic [31:0]               o_hit_count,
  output logic [31:0]               o_req_count,
  // axi ar
  output logic                      o_arvalid,
  input  logic                      i_arready,
  output logic [`ICACHE_ADDR_W-1:0] o_araddr,
  output logic [`AXI_ID_W-1:0]      o_arid,
  output logic [7:0]                o_arlen,
  output logic [2:0]                o_arsize,
  output logic [1:0]                o_arburst,
  // axi r
  output logic                      o_rready,
  input  logic                      i_rvalid,
  input  logic [`AXI_DATA_W-1:0]    i_rdata,
  input  logic                      i_rlast,
  input  logic [1:0]                i_rresp,
  input  logic [`AXI_ID_W-1:0]      i_rid
);

  icache_addr_t                  tag_addr;
  logic                          tag_rd_en, tag_fill_en, tag_fill_way, tag_touch_en;
  logic                          tag_hit, tag_hit_way, tag_victim_way;
  logic [3:0]                    data_cen, data_wen;
  logic [`ICACHE_INDEX_W-1:0]    data_addr;
  logic [3:0][`ICACHE_BANK_W-1:0] data_wmask, data_wdata, data_rdata;

  refill_if refill_bus ();

  icache_ctrl icache_ctrl_i (
    .clk(clk), .i_reset(i_reset),
    .i_req(i_req), .i_addr(i_addr), .o_req_ready(o_req_ready),
    .o_rdata(o_rdata), .o_rvalid(o_rvalid),
    .o_hit_count(o_hit_count), .o_req_count(o_req_count),
    .rd(refill_bus.ctrl),
    .o_tag_rd_en(tag_rd_en), .o_tag_addr(tag_addr),
    .o_tag_fill_en(tag_fill_en), .o_tag_fill_way(tag_fill_way),
    .o_tag_touch_en(tag_touch_en), .i_tag_hit(tag_hit),
    .i_tag_hit_way(tag_hit_way), .i_tag_victim_way(tag_victim_way),
    .o_data_cen(data_cen), .o_data_wen(data_wen), .o_data_addr(data_addr),
    .o_data_wmask(data_wmask), .o_data_wdata(data_wdata), .i_data_rdata(data_rdata)
  );

  icache_tag_array icache_tag_array_i (
    .clk(clk), .i_reset(i_reset),
    .i_rd_en(tag_rd_en), .i_addr(tag_addr),
    .i_fill_en(tag_fill_en), .i_fill_way(tag_fill_way), .i_touch_en(tag_touch_en),
    .o_hit(tag_hit), .o_hit_way(tag_hit_way), .o_victim_way(tag_victim_way)
  );

  icache_data_array icache_data_array_i (
    .clk(clk),
    .i_cen(data_cen), .i_wen(data_wen), .i_addr(data_addr),
    .i_wmask(data_wmask), .i_wdata(data_wdata), .o_rdata(data_rdata)
  );

  axi_read_master axi_read_master_i (
    .clk(clk), .i_reset(i_reset),
    .rd(refill_bus.master),
    .o_arvalid(o_arvalid), .i_arready(i_arready), .o_araddr(o_araddr),
    .o_arid(o_arid), .o_arlen(o_arlen), .o_arsize(o_arsize), .o_arburst(o_arburst),
    .o_rready(o_rready), .i_rvalid(i_rvalid), .i_rdata(i_rdata),
    .i_rlast(i_rlast), .i_rresp(i_rresp), .i_rid(i_rid)
  );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real HALF_PERIOD_NS = 2.0,
  parameter int  RESET_CYCLES   = 3
) (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

  // reset covers the first rising edges, released on a falling edge
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0;
  end

endmodule

// File: verification/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  localparam int RESET_TIMEOUT = 20;
  localparam int READY_TIMEOUT = 100;
  localparam int FETCH_TIMEOUT = 200;
  localparam int BEAT_TIMEOUT  = 50;

  logic        clk, i_reset;
  logic        i_req;
  logic [31:0] i_addr;
  logic        o_req_ready, o_rvalid;
  logic [63:0] o_rdata;
  logic [31:0] o_hit_count, o_req_count;
  logic        o_arvalid, i_arready;
  logic [31:0] o_araddr;
  logic [3:0]  o_arid, i_rid;
  logic [7:0]  o_arlen;
  logic [2:0]  o_arsize;
  logic [1:0]  o_arburst, i_rresp;
  logic        o_rready, i_rvalid, i_rlast;
  logic [63:0] i_rdata;

  int unsigned checks, errors, errors_at_test_start, tests_run;
  int unsigned ar_count, req_sent, hits_expected;
  logic [31:0] lfsr_state = 32'he5a76cb5;

  tb_clock_gen clock_gen_i (.o_clk(clk), .o_reset(i_reset));

  icache_top icache_top_i (.*);

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one step per bit drawn
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] act,
                             input logic [63:0] exp);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("at %0t: %s", $time, what);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (errors == errors_at_test_start) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - errors_at_test_start);
    end
    errors_at_test_start = errors;
  endtask

  // one fetch, called on a falling edge
  task automatic fetch(input logic [31:0] addr, input logic expect_hit);
    int unsigned wait_cycles;
    int unsigned ar_before;
    logic [31:0] hits_before;
    logic [31:0] dw_addr;
    wait_cycles = 0;
    while (!o_req_ready) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > READY_TIMEOUT) stop_on_timeout("o_req_ready");
    end
    ar_before   = ar_count;
    hits_before = o_hit_count;
    i_req  = 1'b1;
    i_addr = addr;
    @(negedge clk);
    i_req = 1'b0;
    req_sent++;
    wait_cycles = 1;
    while (!o_rvalid) begin
      check_true(!o_req_ready, "o_req_ready went high while a fetch was in flight");
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > FETCH_TIMEOUT) stop_on_timeout("o_rvalid");
    end
    dw_addr = {addr[31:3], 3'b000};
    check_value("o_rdata", o_rdata, {dw_addr, ~dw_addr});
    if (expect_hit) begin
      hits_expected++;
      check_value("o_rvalid latency", 64'(wait_cycles), 64'd2);
      check_value("ar burst count", 64'(ar_count - ar_before), 64'd0);
      check_value("o_hit_count", 64'(o_hit_count), 64'(hits_before + 32'd1));
    end else begin
      check_value("ar burst count", 64'(ar_count - ar_before), 64'd1);
      check_value("o_hit_count", 64'(o_hit_count), 64'(hits_before));
    end
  endtask

  // memory model: beat at byte address A carries {A, ~A}
  task automatic serve_burst();
    logic [31:0] beat_addr;
    int unsigned wait_cycles;
    ar_count++;
    beat_addr = o_araddr;
    check_value("o_araddr offset", 64'(o_araddr[4:0]), 64'd0);
    check_value("o_arid", 64'(o_arid), 64'd0);
    check_value("o_arlen", 64'(o_arlen), 64'd3);
    check_value("o_arsize", 64'(o_arsize), 64'd3);
    check_value("o_arburst", 64'(o_arburst), 64'd1);
    repeat (random_bits(2)) @(negedge clk);
    i_arready = 1'b1;
    @(negedge clk);
    i_arready = 1'b0;
    for (int beat = 0; beat < 4; beat++) begin
      repeat (random_bits(2)) @(negedge clk);
      i_rvalid = 1'b1;
      i_rdata  = {beat_addr, ~beat_addr};
      i_rlast  = (beat == 3);
      i_rid    = o_arid;
      wait_cycles = 0;
      while (!o_rready) begin
        @(negedge clk);
        wait_cycles++;
        if (wait_cycles > BEAT_TIMEOUT) stop_on_timeout("o_rready");
      end
      // the beat was taken on the rising edge just passed
      @(negedge clk);
      i_rvalid  = 1'b0;
      i_rlast   = 1'b0;
      beat_addr = beat_addr + 32'd8;
    end
  endtask

  initial begin : axi_memory
    i_arready = 1'b0;
    i_rvalid  = 1'b0;
    i_rdata   = '0;
    i_rlast   = 1'b0;
    i_rresp   = 2'b00;
    i_rid     = '0;
    forever begin
      @(negedge clk);
      if (o_arvalid) serve_burst();
    end
  end

  initial begin : main_sequence
    int unsigned wait_cycles;
    logic [31:0] addr, offset;
    logic [31:0] x_addr, y_addr, z_addr;
    i_req  = 1'b0;
    i_addr = '0;
    checks = 0;
    errors = 0;
    errors_at_test_start = 0;
    tests_run = 0;
    ar_count = 0;
    req_sent = 0;
    hits_expected = 0;
    @(negedge clk);
    wait_cycles = 0;
    while (i_reset) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > RESET_TIMEOUT) stop_on_timeout("reset release");
    end

    fetch(32'h8000_0108, 1'b0);
    report_test("cold_miss");

    fetch(32'h8000_0110, 1'b1);
    report_test("hit");

    // odd doublewords use an unaligned byte address
    for (int i = 0; i < 4; i++) begin
      fetch(32'h8000_0100 + i * 8 + (i % 2) * 4, 1'b1);
    end
    report_test("dword_select");

    // three tags on set 2
    x_addr = 32'h8000_0040;
    y_addr = 32'h8000_1048;
    z_addr = 32'h8000_2050;
    fetch(x_addr, 1'b0);
    fetch(y_addr, 1'b0);
    fetch(x_addr, 1'b1);
    fetch(z_addr, 1'b0);
    fetch(x_addr, 1'b1);
    fetch(y_addr, 1'b0);
    report_test("two_way_lru");

    // fresh tag each round, random set and offset
    for (int k = 0; k < 8; k++) begin
      addr = 32'h4000_0000 + (k << 11) + random_bits(11);
      fetch(addr, 1'b0);
      offset = random_bits(5);
      fetch({addr[31:5], offset[4:0]}, 1'b1);
    end
    report_test("back_pressure");

    check_value("o_req_count", 64'(o_req_count), 64'(req_sent));
    check_value("o_hit_count", 64'(o_hit_count), 64'(hits_expected));
    report_test("counters");

    $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+hw
hw/icache_pkg.sv
hw/refill_if.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_ctrl.sv
hw/axi_read_master.sv
hw/icache_top.sv
verification/tb_clock_gen.sv
verification/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module icache_tb \
    -f files.f -o icache_sim; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/icache_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'RESULT: PASS'; then
  exit 0
fi
exit 1
